// ==== logic/dfpRound_params.svh ====
`ifndef DFPROUND_PARAMS_SVH
`define DFPROUND_PARAMS_SVH

// ============================================================
// Number format
// ============================================================

// Significand digits of the 96-bit interchange format
`define DFP_DIGITS 25

// Biased exponent at which the leading digit is the units digit
`define DFP_ZERO_EXP 12'h5FF

// Largest biased exponent that the combination field can carry
`define DFP_MAX_EXP 12'hBFF

// ============================================================
// Flow control
// ============================================================

// Result queue entries, equal to the operand credits the producer starts with
`define RQ_DEPTH 4

// Result credits the unit starts with after reset
`define OUT_CREDITS 2

`endif

// ==== logic/dfpFormatPkg.sv ====
`include "dfpRound_params.svh"

package dfpFormatPkg;

	// ============================================================
	// Interchange layout
	// ============================================================

	// The 96-bit DPD word as it travels on the ports
	// Combination field 11110 marks infinity and 1111x with x set marks a NaN
	// The continuation holds eight declets of three digits each
	typedef struct packed {
		logic sign;
		logic [4:0] combo;
		logic [9:0] expCont;
		logic [(`DFP_DIGITS - 1) / 3 * 10 - 1:0] sigCont;
	} dfp96_t;

	// ============================================================
	// Working form
	// ============================================================

	// Sign, full 12-bit biased exponent and one BCD nibble per digit
	// Digit 0 sits in the low nibble, the leading digit in the top nibble
	// The special flag is set for infinities and NaNs, whose other fields
	// carry no meaning
	typedef struct packed {
		logic special;
		logic sign;
		logic [11:0] exp;
		logic [`DFP_DIGITS * 4 - 1:0] sig;
	} dfp96u_t;

endpackage

// ==== logic/dfpOpPkg.sv ====
package dfpOpPkg;

	// ============================================================
	// Rounding opcodes
	// ============================================================

	// Truncate chops toward zero, floor and ceiling round toward the
	// infinities, and nearest breaks a tie away from zero
	typedef enum logic [1:0] {
		RND_TRUNC = 2'd0,
		RND_FLOOR = 2'd1,
		RND_CEIL = 2'd2,
		RND_NEAREST = 2'd3
	} rndOp_t;

	// ============================================================
	// Port payloads
	// ============================================================

	// One operand with the opcode to apply and a tag echoed on the result
	typedef struct packed {
		rndOp_t op;
		logic [3:0] tag;
		dfpFormatPkg::dfp96_t operand;
	} rndReq_t;

	// One finished result in DPD layout
	// Overflow is raised when the carry out of the top digit would need an
	// exponent above the encodable maximum
	typedef struct packed {
		logic [3:0] tag;
		dfpFormatPkg::dfp96_t result;
		logic overflow;
	} rndRes_t;

endpackage

// ==== logic/dpdUnpack.sv ====
`timescale 1ns/1ps
`include "dfpRound_params.svh"

module dpdUnpack (
	input dfpFormatPkg::dfp96_t packedWord,
	output dfpFormatPkg::dfp96u_t unpacked
);
	localparam int decletCount = (`DFP_DIGITS - 1) / 3;

	logic [4:0] combo;
	logic [1:0] expTop;
	logic [3:0] leadDigit;

	// Expand one declet into three BCD digits, most significant first
	// Bit 3 tells whether any digit is 8 or 9, bits 2:1 and 6:5 say which
	function automatic logic [11:0] decodeDeclet(input logic [9:0] b);
		logic [11:0] d;
		if (!b[3])
			d = {1'b0, b[9:7], 1'b0, b[6:4], 1'b0, b[2:0]};
		else begin
			case (b[2:1])
				2'b00: d = {1'b0, b[9:7], 1'b0, b[6:4], 3'b100, b[0]};
				2'b01: d = {1'b0, b[9:7], 3'b100, b[4], 1'b0, b[6:5], b[0]};
				2'b10: d = {3'b100, b[7], 1'b0, b[6:4], 1'b0, b[9:8], b[0]};
				default:
					// Two or three large digits, the kind picked by bits 6:5
					case (b[6:5])
						2'b00: d = {3'b100, b[7], 3'b100, b[4], 1'b0, b[9:8], b[0]};
						2'b01: d = {3'b100, b[7], 1'b0, b[9:8], b[4], 3'b100, b[0]};
						2'b10: d = {1'b0, b[9:7], 3'b100, b[4], 3'b100, b[0]};
						default: d = {3'b100, b[7], 3'b100, b[4], 3'b100, b[0]};
					endcase
			endcase
		end
		return d;
	endfunction

	// Combination field split
	// A leading digit of 0 to 7 takes three bits after the exponent top bits,
	// while 8 and 9 use the 11 prefix and keep only their low bit
	always_comb begin
		combo = packedWord.combo;
		if (combo[4:3] != 2'b11) begin
			expTop = combo[4:3];
			leadDigit = {1'b0, combo[2:0]};
		end else begin
			expTop = combo[2:1];
			leadDigit = {3'b100, combo[0]};
		end
	end

	always_comb begin
		unpacked.special = (combo[4:1] == 4'b1111);
		unpacked.sign = packedWord.sign;
		unpacked.exp = {expTop, packedWord.expCont};
		unpacked.sig[`DFP_DIGITS * 4 - 1 -: 4] = leadDigit;
		// Declet 0 holds the three lowest digits
		for (int i = 0; i < decletCount; i++)
			unpacked.sig[i * 12 +: 12] = decodeDeclet(packedWord.sigCont[i * 10 +: 10]);
	end

endmodule

// ==== logic/dpdPack.sv ====
`timescale 1ns/1ps
`include "dfpRound_params.svh"

module dpdPack (
	input dfpFormatPkg::dfp96u_t unpacked,
	output dfpFormatPkg::dfp96_t packedWord
);
	localparam int decletCount = (`DFP_DIGITS - 1) / 3;

	logic [1:0] expTop;
	logic [3:0] leadDigit;

	// Compress three BCD digits into one declet
	// The large-digit pattern of the three top bits selects the layout
	function automatic logic [9:0] encodeDeclet(input logic [11:0] d);
		logic [3:0] d2;
		logic [3:0] d1;
		logic [3:0] d0;
		logic [9:0] b;
		d2 = d[11:8];
		d1 = d[7:4];
		d0 = d[3:0];
		case ({d2[3], d1[3], d0[3]})
			3'b000: b = {d2[2:0], d1[2:0], 1'b0, d0[2:0]};
			3'b001: b = {d2[2:0], d1[2:0], 3'b100, d0[0]};
			3'b010: b = {d2[2:0], d0[2:1], d1[0], 3'b101, d0[0]};
			3'b100: b = {d0[2:1], d2[0], d1[2:0], 3'b110, d0[0]};
			3'b011: b = {d2[2:0], 2'b10, d1[0], 3'b111, d0[0]};
			3'b101: b = {d1[2:1], d2[0], 2'b01, d1[0], 3'b111, d0[0]};
			3'b110: b = {d0[2:1], d2[0], 2'b00, d1[0], 3'b111, d0[0]};
			default: b = {2'b00, d2[0], 2'b11, d1[0], 3'b111, d0[0]};
		endcase
		return b;
	endfunction

	// Inverse of the unpacker
	// An infinity or NaN is not rebuilt here, since its original word rides
	// along the rounding core and replaces this output at the top level
	always_comb begin
		leadDigit = unpacked.sig[`DFP_DIGITS * 4 - 1 -: 4];
		expTop = unpacked.exp[11:10];
		packedWord.sign = unpacked.sign;
		packedWord.expCont = unpacked.exp[9:0];
		// Exponent top bits never reach 11, so no 1111x code comes out of here
		if (leadDigit[3])
			packedWord.combo = {2'b11, expTop, leadDigit[0]};
		else
			packedWord.combo = {expTop, leadDigit[2:0]};
		for (int i = 0; i < decletCount; i++)
			packedWord.sigCont[i * 10 +: 10] = encodeDeclet(unpacked.sig[i * 12 +: 12]);
	end

endmodule

// ==== logic/dfpIntRound.sv ====
`timescale 1ns/1ps
`include "dfpRound_params.svh"

module dfpIntRound (
	input logic clk,
	input logic reset,
	input logic adv0,
	input logic adv1,
	input dfpOpPkg::rndOp_t op,
	input logic [3:0] tagIn,
	input dfpFormatPkg::dfp96_t rawIn,
	input dfpFormatPkg::dfp96u_t opnd,
	output logic [3:0] tagOut,
	output dfpFormatPkg::dfp96u_t result,
	output dfpFormatPkg::dfp96_t rawOut,
	output logic overflow
);
	import dfpFormatPkg::*;
	import dfpOpPkg::*;

	localparam int sigWidth = `DFP_DIGITS * 4;
	localparam logic [sigWidth-1:0] topOne = {4'h1, {(sigWidth - 4){1'b0}}};

	// Everything the second stage needs to decide and apply the increment
	typedef struct packed {
		rndOp_t op;
		logic [3:0] tag;
		logic special;
		logic sign;
		logic [11:0] exp;
		logic [sigWidth-1:0] kept;
		logic [4:0] unitPos;
		logic subUnit;
		logic sticky;
		logic halfUp;
		logic allNine;
	} stage1_t;

	stage1_t s1Next;
	stage1_t s1;
	dfp96_t raw1;
	logic [12:0] expOff;
	logic [4:0] fracDigits;
	logic subUnit;
	logic tenthsValid;
	logic incr;
	logic carry;
	logic [3:0] digit;
	logic [sigWidth-1:0] sum;
	logic [12:0] expUp;
	dfp96u_t resNext;
	logic ovfNext;

	// ============================================================
	// Stage one: fraction mask and rounding facts
	// ============================================================

	// Digits below the units position, from all 25 down to none
	always_comb begin
		expOff = {1'b0, opnd.exp} - {1'b0, `DFP_ZERO_EXP};
		subUnit = (opnd.exp < `DFP_ZERO_EXP);
		// The tenths digit only lies inside the significand from one below zero exp
		tenthsValid = (opnd.exp >= 12'(`DFP_ZERO_EXP - 1));
		if (subUnit)
			fracDigits = 5'(`DFP_DIGITS);
		else if (expOff > 13'(`DFP_DIGITS - 1))
			fracDigits = 5'd0;
		else
			fracDigits = 5'(`DFP_DIGITS - 1) - expOff[4:0];
	end

	always_comb begin
		s1Next.op = op;
		s1Next.tag = tagIn;
		s1Next.special = opnd.special;
		s1Next.sign = opnd.sign;
		s1Next.exp = opnd.exp;
		s1Next.unitPos = fracDigits;
		s1Next.subUnit = subUnit;
		s1Next.kept = opnd.sig;
		s1Next.sticky = 1'b0;
		s1Next.halfUp = 1'b0;
		s1Next.allNine = ~subUnit;
		for (int g = 0; g < `DFP_DIGITS; g++) begin
			if (5'(g) < fracDigits) begin
				s1Next.kept[g * 4 +: 4] = 4'h0;
				s1Next.sticky = s1Next.sticky | (opnd.sig[g * 4 +: 4] != 4'h0);
			end else if (opnd.sig[g * 4 +: 4] != 4'h9)
				s1Next.allNine = 1'b0;
			// First dropped digit decides a nearest rounding
			if (5'(g + 1) == fracDigits && tenthsValid)
				s1Next.halfUp = (opnd.sig[g * 4 +: 4] >= 4'd5);
		end
	end

	always_ff @(posedge clk) begin
		if (adv0) begin
			s1 <= s1Next;
			raw1 <= rawIn;
		end
	end

	// ============================================================
	// Stage two: increment decision and BCD add
	// ============================================================

	always_comb begin
		unique case (s1.op)
			RND_TRUNC: incr = 1'b0;
			RND_FLOOR: incr = s1.sign & s1.sticky;
			RND_CEIL: incr = ~s1.sign & s1.sticky;
			RND_NEAREST: incr = s1.halfUp;
		endcase
	end

	// Ripple a one in at the units digit; a carry out of the top digit is
	// covered by the all-nines case below
	always_comb begin
		carry = 1'b0;
		digit = 4'h0;
		sum = s1.kept;
		for (int g = 0; g < `DFP_DIGITS; g++) begin
			digit = s1.kept[g * 4 +: 4] + {3'b000, carry | (incr && 5'(g) == s1.unitPos)};
			carry = (digit == 4'd10);
			sum[g * 4 +: 4] = carry ? 4'd0 : digit;
		end
	end

	always_comb begin
		expUp = {1'b0, s1.exp} + 13'd1;
		resNext.special = s1.special;
		resNext.sign = s1.sign;
		resNext.exp = s1.exp;
		resNext.sig = sum;
		ovfNext = 1'b0;
		if (!s1.special) begin
			if (s1.subUnit) begin
				// Below one, either a bare 1 or a signed zero
				resNext.exp = `DFP_ZERO_EXP;
				resNext.sig = incr ? topOne : '0;
			end else if (incr && s1.allNine) begin
				if (expUp > {1'b0, `DFP_MAX_EXP}) begin
					ovfNext = 1'b1;
					resNext.sig = s1.kept;
				end else begin
					resNext.exp = expUp[11:0];
					resNext.sig = topOne;
				end
			end else if (sum == '0 && s1.sticky)
				resNext.exp = `DFP_ZERO_EXP;
		end
	end

	always_ff @(posedge clk) begin
		if (adv1) begin
			result <= resNext;
			tagOut <= s1.tag;
			rawOut <= raw1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			overflow <= 1'b0;
		else if (adv1)
			overflow <= ovfNext;
	end

endmodule

// ==== logic/resultQueue.sv ====
`timescale 1ns/1ps
`include "dfpRound_params.svh"

module resultQueue (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input dfpOpPkg::rndRes_t din,
	output dfpOpPkg::rndRes_t dout,
	output logic empty
);
	import dfpOpPkg::*;

	// Depth is a power of two, so the pointers simply wrap
	localparam int ptrWidth = $clog2(`RQ_DEPTH);

	rndRes_t mem [`RQ_DEPTH];
	logic [ptrWidth-1:0] rdPtr;
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth:0] count;

	// Head is visible without a read cycle
	assign dout = mem[rdPtr];
	assign empty = (count == '0);

	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= din;
	end

	// Slots are reserved at issue, so a push never meets a full queue
	always_ff @(posedge clk) begin
		if (reset) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== logic/dfpRoundCtrl.sv ====
`timescale 1ns/1ps
`include "dfpRound_params.svh"

module dfpRoundCtrl (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input logic resCredit,
	input logic queueEmpty,
	output logic adv0,
	output logic adv1,
	output logic push,
	output logic pop,
	output logic reqCredit,
	output logic resValid
);
	localparam int creditWidth = $clog2(`OUT_CREDITS + 1);

	// Bit 0 follows the first pipeline register, bit 1 the second
	logic [1:0] stageValid;
	logic [creditWidth-1:0] credits;

	// ============================================================
	// Pipeline sequencing
	// ============================================================

	// No stall exists inside the pipe, a valid item moves every cycle
	assign adv0 = reqValid;
	assign adv1 = stageValid[0];
	assign push = stageValid[1];

	always_ff @(posedge clk) begin
		if (reset)
			stageValid <= 2'b00;
		else
			stageValid <= {stageValid[0], reqValid};
	end

	// ============================================================
	// Credits
	// ============================================================

	// A result leaves whenever one is queued and the consumer has room
	assign resValid = ~queueEmpty && (credits != '0);
	assign pop = resValid;
	// The freed slot goes straight back to the producer
	assign reqCredit = pop;

	// A returned credit and a send in the same cycle leave the count alone
	always_ff @(posedge clk) begin
		if (reset)
			credits <= creditWidth'(`OUT_CREDITS);
		else begin
			case ({resCredit, pop})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

// ==== logic/dfpRoundUnit.sv ====
`timescale 1ns/1ps

module dfpRoundUnit (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input dfpOpPkg::rndReq_t req,
	output logic reqCredit,
	output logic resValid,
	output dfpOpPkg::rndRes_t res,
	input logic resCredit
);
	import dfpFormatPkg::*;
	import dfpOpPkg::*;

	logic adv0;
	logic adv1;
	logic push;
	logic pop;
	logic queueEmpty;
	dfp96u_t opndU;
	dfp96u_t roundU;
	dfp96_t rawOut;
	dfp96_t packedRes;
	logic [3:0] tagOut;
	logic overflow;
	rndRes_t queueIn;

	dfpRoundCtrl ctrl (
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.resCredit(resCredit),
		.queueEmpty(queueEmpty),
		.adv0(adv0),
		.adv1(adv1),
		.push(push),
		.pop(pop),
		.reqCredit(reqCredit),
		.resValid(resValid)
	);

	dpdUnpack unpack (
		.packedWord(req.operand),
		.unpacked(opndU)
	);

	// Two register stages between the decoder and the encoder
	dfpIntRound core (
		.clk(clk),
		.reset(reset),
		.adv0(adv0),
		.adv1(adv1),
		.op(req.op),
		.tagIn(req.tag),
		.rawIn(req.operand),
		.opnd(opndU),
		.tagOut(tagOut),
		.result(roundU),
		.rawOut(rawOut),
		.overflow(overflow)
	);

	dpdPack pack (
		.unpacked(roundU),
		.packedWord(packedRes)
	);

	// Infinities and NaNs leave as the exact word that came in
	assign queueIn.tag = tagOut;
	assign queueIn.result = roundU.special ? rawOut : packedRes;
	assign queueIn.overflow = overflow;

	resultQueue resQueue (
		.clk(clk),
		.reset(reset),
		.push(push),
		.pop(pop),
		.din(queueIn),
		.dout(res),
		.empty(queueEmpty)
	);

endmodule

// ==== tb/dpdTbCodec.svh ====
`ifndef DPDTBCODEC_SVH
`define DPDTBCODEC_SVH

// ============================================================
// Test vector helpers
// ============================================================

// Turn a string of decimal digits into 25 BCD nibbles
// The string is right aligned, so missing leading digits read as zero
function automatic logic [99:0] digitsFromString(input string s);
	logic [99:0] bcd;
	int n;
	bcd = '0;
	n = s.len();
	for (int i = 0; i < n && i < 25; i++)
		bcd[i * 4 +: 4] = 4'(s[n - 1 - i] - 8'h30);
	return bcd;
endfunction

// Pack three BCD digits into one declet following the IEEE 754 DPD table
function automatic logic [9:0] declet(input logic [3:0] h, input logic [3:0] m,
		input logic [3:0] l);
	logic [9:0] b;
	if (!h[3] && !m[3] && !l[3])
		b = {h[2:0], m[2:0], 1'b0, l[2:0]};
	else if (!h[3] && !m[3])
		b = {h[2:0], m[2:0], 3'b100, l[0]};
	else if (!h[3] && !l[3])
		b = {h[2:0], l[2:1], m[0], 3'b101, l[0]};
	else if (!m[3] && !l[3])
		b = {l[2:1], h[0], m[2:0], 3'b110, l[0]};
	else if (!h[3])
		b = {h[2:0], 2'b10, m[0], 3'b111, l[0]};
	else if (!m[3])
		b = {m[2:1], h[0], 2'b01, m[0], 3'b111, l[0]};
	else if (!l[3])
		b = {l[2:1], h[0], 2'b00, m[0], 3'b111, l[0]};
	else
		b = {2'b00, h[0], 2'b11, m[0], 3'b111, l[0]};
	return b;
endfunction

// Build the whole 96-bit word from sign, biased exponent and digit string
function automatic logic [95:0] dpdWord(input logic sign, input logic [11:0] exp,
		input string s);
	logic [99:0] bcd;
	logic [4:0] combo;
	logic [79:0] cont;
	bcd = digitsFromString(s);
	// Leading digits 8 and 9 need the long combination form
	if (bcd[99])
		combo = {2'b11, exp[11:10], bcd[96]};
	else
		combo = {exp[11:10], bcd[98:96]};
	for (int i = 0; i < 8; i++)
		cont[i * 10 +: 10] = declet(bcd[i * 12 + 8 +: 4], bcd[i * 12 + 4 +: 4], bcd[i * 12 +: 4]);
	return {sign, combo, exp[9:0], cont};
endfunction

// 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1; the new bit lands in bit 0
function automatic logic [31:0] lfsrStep(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

// ==== tb/dfpRoundUnit_tb.sv ====
`timescale 1ns/1ps
`include "dfpRound_params.svh"

module dfpRoundUnit_tb;
	import dfpFormatPkg::*;
	import dfpOpPkg::*;

	`include "dpdTbCodec.svh"

	localparam int numCases = 16;
	localparam int burstLen = 8;
	localparam int cycleLimit = (numCases + burstLen) * 20 + 100;

	logic clk;
	logic reset;
	logic reqValid;
	rndReq_t req;
	logic reqCredit;
	logic resValid;
	rndRes_t res;
	logic resCredit;

	// Stimulus and expected values, one row per case
	rndOp_t caseOp [numCases];
	logic [95:0] caseIn [numCases];
	logic [95:0] caseExp [numCases];
	logic caseOvf [numCases];
	string caseName [numCases];

	// Results still owed by the DUT, in the order the requests went out
	logic [95:0] expWordQ [$];
	logic expOvfQ [$];
	logic [3:0] expTagQ [$];
	string expNameQ [$];

	int sentTotal;
	int creditsBack;
	int received;
	int owed;
	int returned;
	int waitLeft;
	int cycles;
	int testsRun;
	int testsFailed;
	int windowResults;
	int windowCredits;
	int windowSent;
	logic withhold;
	logic [31:0] lfsrState;

	dfpRoundUnit UUT (
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.req(req),
		.reqCredit(reqCredit),
		.resValid(resValid),
		.res(res),
		.resCredit(resCredit)
	);

	always #4 clk = ~clk;

	// ============================================================
	// Case table
	// ============================================================

	task automatic addCase(input int i, input string name, input rndOp_t op, input logic s,
			input logic [11:0] e, input string d, input logic es, input logic [11:0] ee,
			input string ed, input logic ovf);
		caseName[i] = name;
		caseOp[i] = op;
		caseIn[i] = dpdWord(s, e, d);
		caseExp[i] = dpdWord(es, ee, ed);
		caseOvf[i] = ovf;
	endtask

	// Infinities and NaNs must come back as the very same word
	task automatic addSpecial(input int i, input string name, input rndOp_t op,
			input logic [95:0] w);
		caseName[i] = name;
		caseOp[i] = op;
		caseIn[i] = w;
		caseExp[i] = w;
		caseOvf[i] = 1'b0;
	endtask

	task automatic buildTable();
		addCase(0, "trunc 1 integral digit", RND_TRUNC, 0, 12'h5FF,
			"7123456789012345678901234", 0, 12'h5FF, "7000000000000000000000000", 0);
		addCase(1, "trunc negative 10 digits", RND_TRUNC, 1, 12'h608,
			"1234567890123456789012345", 1, 12'h608, "1234567890000000000000000", 0);
		addCase(2, "trunc 24 integral digits", RND_TRUNC, 0, 12'h616,
			"9876543210987654321098765", 0, 12'h616, "9876543210987654321098760", 0);
		addCase(3, "trunc below one", RND_TRUNC, 1, 12'h5FE,
			"9999999999999999999999999", 1, 12'h5FF, "0", 0);
		addCase(4, "floor negative", RND_FLOOR, 1, 12'h608,
			"1234567890500000000000000", 1, 12'h608, "1234567891000000000000000", 0);
		addCase(5, "ceil positive", RND_CEIL, 0, 12'h608,
			"1234567890500000000000000", 0, 12'h608, "1234567891000000000000000", 0);
		addCase(6, "nearest tie at 5", RND_NEAREST, 0, 12'h5FF,
			"2500000000000000000000000", 0, 12'h5FF, "3000000000000000000000000", 0);
		addCase(7, "nearest below half", RND_NEAREST, 1, 12'h5FF,
			"2499999999999999999999999", 1, 12'h5FF, "2000000000000000000000000", 0);
		addCase(8, "ceil sub-unit to one", RND_CEIL, 0, 12'h5FE,
			"1000000000000000000000000", 0, 12'h5FF, "1000000000000000000000000", 0);
		addCase(9, "floor sub-unit to zero", RND_FLOOR, 0, 12'h5FE,
			"1000000000000000000000000", 0, 12'h5FF, "0", 0);
		addCase(10, "ceil all nines carry", RND_CEIL, 0, 12'h608,
			"9999999999100000000000000", 0, 12'h609, "1000000000000000000000000", 0);
		// At the top exponent nothing is fraction, so no carry can appear
		addCase(11, "ceil nines at max exp", RND_CEIL, 0, `DFP_MAX_EXP,
			"9999999999999999999999999", 0, `DFP_MAX_EXP, "9999999999999999999999999", 0);
		addSpecial(12, "infinity passthrough", RND_NEAREST, 96'h7800_0000_0000_0000_0000_0000);
		addSpecial(13, "NaN passthrough", RND_FLOOR, 96'hFC00_0000_0000_0000_1234_5678);
		addCase(14, "already integral", RND_CEIL, 1, 12'h617,
			"1234567890123456789012345", 1, 12'h617, "1234567890123456789012345", 0);
		addCase(15, "nearest half to one", RND_NEAREST, 0, 12'h5FE,
			"5000000000000000000000000", 0, 12'h5FF, "1000000000000000000000000", 0);
	endtask

	// ============================================================
	// Producer
	// ============================================================

	// Sends table rows first to first+count-1, spending one credit per request
	task automatic sendRange(input int first, input int count);
		int k;
		k = 0;
		while (k < count) begin
			@(posedge clk);
			#1;
			if (`RQ_DEPTH + creditsBack - sentTotal > 0) begin
				reqValid = 1'b1;
				req.op = caseOp[first + k];
				req.tag = 4'(first + k);
				req.operand = caseIn[first + k];
				expWordQ.push_back(caseExp[first + k]);
				expOvfQ.push_back(caseOvf[first + k]);
				expTagQ.push_back(4'(first + k));
				expNameQ.push_back(caseName[first + k]);
				sentTotal++;
				k++;
			end else
				reqValid = 1'b0;
		end
		@(posedge clk);
		#1;
		reqValid = 1'b0;
	endtask

	// ============================================================
	// Consumer and checks
	// ============================================================

	task automatic report(input logic ok, input string name, input string fault);
		testsRun++;
		if (ok)
			$display("ok   %s", name);
		else begin
			testsFailed++;
			$display("%s", fault);
		end
	endtask

	task automatic checkResult(input rndRes_t r);
		logic [95:0] w;
		string name;
		testsRun++;
		if (expWordQ.size() == 0) begin
			testsFailed++;
			$display("A result arrived with no request outstanding");
			return;
		end
		w = expWordQ.pop_front();
		name = expNameQ.pop_front();
		if (r.tag != expTagQ[0]) begin
			testsFailed++;
			$display("FAIL res.tag got %h expected %h (%s)", r.tag, expTagQ[0], name);
		end else if (r.result != w) begin
			testsFailed++;
			$display("FAIL res.result got %h expected %h (%s)", r.result, w, name);
		end else if (r.overflow != expOvfQ[0]) begin
			testsFailed++;
			$display("FAIL res.overflow got %h expected %h (%s)", r.overflow, expOvfQ[0], name);
		end else
			$display("ok   tag %0d %s", r.tag, name);
		void'(expTagQ.pop_front());
		void'(expOvfQ.pop_front());
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			if (reqCredit) begin
				creditsBack++;
				if (withhold)
					windowCredits++;
			end
			if (resValid) begin
				checkResult(res);
				received++;
				owed++;
				if (withhold)
					windowResults++;
			end
		end
	end

	function automatic int randDelay();
		logic [1:0] d;
		lfsrState = lfsrStep(lfsrState);
		d[0] = lfsrState[0];
		lfsrState = lfsrStep(lfsrState);
		d[1] = lfsrState[0];
		return int'(d);
	endfunction

	// Each received result earns one credit back after 0 to 3 cycles
	always @(posedge clk) begin
		#1;
		resCredit = 1'b0;
		if (!reset && !withhold && owed > returned) begin
			if (waitLeft == 0) begin
				resCredit = 1'b1;
				returned++;
				waitLeft = randDelay();
			end else
				waitLeft--;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("Timeout after %0d cycles with %0d results received", cycles, received);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		reqValid = 1'b0;
		req = '0;
		resCredit = 1'b0;
		withhold = 1'b0;
		lfsrState = 32'hd88e73b6;
		waitLeft = 0;
		buildTable();
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		// Whole table with credits flowing normally
		sendRange(0, numCases);
		wait (received == numCases);

		// Back-pressure window with the consumer holding its credits
		withhold = 1'b1;
		windowSent = sentTotal;
		fork
			sendRange(0, burstLen);
			begin
				repeat (30) @(posedge clk);
				// Later than the producer and the consumer drive in this cycle
				#2;
				windowSent = sentTotal - windowSent;
				report(windowResults <= `OUT_CREDITS, "results limited by unit credits",
					"More results left than the unit held credits for");
				report(windowCredits == windowResults, "operand credits follow result pops",
					"Operand credits returned without a matching result pop");
				report(windowSent == `RQ_DEPTH + windowCredits, "producer stalls without credits",
					"Producer did not stall once its operand credits ran out");
				withhold = 1'b0;
			end
		join
		wait (received == numCases + burstLen);
		repeat (10) @(posedge clk);
		report(received == numCases + burstLen && expWordQ.size() == 0,
			"result count after back-pressure",
			"Result count after back-pressure does not match the requests");

		$display("Tests run %0d, failed %0d", testsRun, testsFailed);
		if (testsFailed == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== dfpRoundUnit.f ====
+incdir+logic
+incdir+tb
logic/dfpFormatPkg.sv
logic/dfpOpPkg.sv
logic/dpdUnpack.sv
logic/dpdPack.sv
logic/dfpIntRound.sv
logic/resultQueue.sv
logic/dfpRoundCtrl.sv
logic/dfpRoundUnit.sv
tb/dfpRoundUnit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing -j 0
TOP       ?= dfpRoundUnit_tb
FILELIST  ?= dfpRoundUnit.f
LOG       ?= sim.log
OBJDIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
